// ==== rx_frontend.f ====
+incdir+testbench
logic/rx_frontend_pkg.sv
logic/rx_settings_regs.sv
logic/rx_iq_select.sv
logic/rx_dc_offset.sv
logic/rx_iq_balance.sv
logic/rx_round_sd.sv
logic/rx_frontend.sv
testbench/rx_frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the receive front end testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module rx_frontend_tb -f rx_frontend.f -o rx_frontend_sim

./obj_dir/rx_frontend_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
  echo "run ended without a result, see sim.log"
  exit 1
fi
echo "run passed"

// ==== testbench/rx_frontend_model.svh ====
// reference model of the receive front end.
// integer arithmetic per stage, state advanced once per accepted sample.

`ifndef RX_FRONTEND_MODEL_SVH
`define RX_FRONTEND_MODEL_SVH

// flags msb first: invert_i, invert_q, realmode, swap_iq.
logic [3:0] m_flags;
// index 0 is the magnitude coefficient, 1 the phase coefficient.
longint     m_coef  [2];
// per channel state, index 0 is I.
longint     m_acc   [2];
logic       m_fixed [2];
longint     m_err   [2];

// two's complement wrap into a signed field.
function automatic longint wrap_to(input longint x, input int bits);
  longint span;
  longint r;
  span = longint'(1) << bits;
  r = x & (span - 1);
  if (r >= (span >>> 1)) begin
    r = r - span;
  end
  return r;
endfunction

function automatic longint clamp_to(input longint x, input int bits);
  longint hi;
  hi = (longint'(1) << (bits - 1)) - 1;
  if (x > hi) begin
    return hi;
  end
  if (x < -hi - 1) begin
    return -hi - 1;
  end
  return x;
endfunction

function automatic void model_reset();
  m_flags = '0;
  for (int c = 0; c < 2; c++) begin
    m_coef[c]  = 0;
    m_acc[c]   = 0;
    m_fixed[c] = 1'b0;
    m_err[c]   = 0;
  end
endfunction

function automatic void model_write(input logic [7:0] addr, input logic [31:0] data);
  logic signed [17:0] coef;
  logic signed [23:0] offset;
  coef   = data[17:0];
  offset = data[23:0];
  if (addr == SR_SWAP) begin
    m_flags = data[3:0];
  end
  if (addr == SR_MAG) begin
    m_coef[0] = longint'(coef);
  end
  if (addr == SR_PHASE) begin
    m_coef[1] = longint'(coef);
  end
  for (int c = 0; c < 2; c++) begin
    if (addr == ((c == 0) ? SR_OFFSET_I : SR_OFFSET_Q)) begin
      m_acc[c]   = wrap_to(longint'(offset) * 256, 32);
      m_fixed[c] = data[31];
    end
  end
endfunction

function automatic rx_frontend_pkg::adc_sample_t model_sample(
  input rx_frontend_pkg::adc_sample_t adc
);
  longint ch [2];
  longint diff;
  longint i_top;
  longint sum;
  rx_frontend_pkg::adc_sample_t res;
  // swap, then ones' complement, then real mode.
  ch[0] = longint'(m_flags[0] ? adc.q : adc.i);
  ch[1] = longint'(m_flags[0] ? adc.i : adc.q);
  if (m_flags[3]) begin
    ch[0] = -ch[0] - 1;
  end
  if (m_flags[2]) begin
    ch[1] = -ch[1] - 1;
  end
  if (m_flags[1]) begin
    ch[1] = 0;
  end
  for (int c = 0; c < 2; c++) begin
    // offset estimate is the upper 24 bits of the accumulator.
    diff = clamp_to(wrap_to(ch[c] * 256 - (m_acc[c] >>> 8), 25), 24);
    if (!m_fixed[c]) begin
      m_acc[c] = wrap_to(m_acc[c] + diff, 32);
    end
    ch[c] = diff;
  end
  // both products come from the top 18 bits of I.
  i_top = ch[0] >>> 6;
  ch[1] = clamp_to(ch[1] + ((i_top * m_coef[1]) >>> 12), 24);
  ch[0] = clamp_to(ch[0] + ((i_top * m_coef[0]) >>> 12), 24);
  for (int c = 0; c < 2; c++) begin
    sum      = ch[c] + m_err[c];
    m_err[c] = sum & 255;
    ch[c]    = clamp_to(sum >>> 8, 16);
  end
  res.i = ch[0][15:0];
  res.q = ch[1][15:0];
  return res;
endfunction

`endif

// ==== testbench/rx_frontend_tb.sv ====
// testbench for the receive front end.
// random bursts through every stage, checked against an integer model.

`timescale 1ns/1ns

module rx_frontend_tb;

  localparam logic [7:0]  SR_MAG      = 8'd10;
  localparam logic [7:0]  SR_PHASE    = 8'd11;
  localparam logic [7:0]  SR_OFFSET_I = 8'd12;
  localparam logic [7:0]  SR_OFFSET_Q = 8'd13;
  localparam logic [7:0]  SR_SWAP     = 8'd14;
  localparam logic [31:0] FIXED_ZERO  = 32'h8000_0000;
  localparam int IDLE_CYCLES = 8;
  localparam int LATENCY     = 5;
  localparam int BURST_LEN   = 48;
  localparam int MAX_GAP     = 3;
  localparam int N_PHASES    = 9;
  // each phase counted as if every gap were the longest.
  localparam int WATCHDOG_CYCLES = N_PHASES * (BURST_LEN * (MAX_GAP + 1) + IDLE_CYCLES) * 20;

  typedef struct packed {
    logic [31:0]                  cycle;
    rx_frontend_pkg::adc_sample_t value;
  } pending_t;

  logic                           clk;
  logic                           reset;
  rx_frontend_pkg::settings_bus_t set_i;
  logic                           adc_stb_i;
  rx_frontend_pkg::adc_sample_t   adc_i;
  logic                           rx_stb_o;
  rx_frontend_pkg::adc_sample_t   rx_o;

  integer      seed = 32'h6d7caae5;
  logic [31:0] cycle_cnt = '0;
  string       test_name = "reset";
  string       flag_name [4] = '{"swap_iq", "realmode", "invert_q", "invert_i"};
  pending_t    expect_q [$];

  `include "rx_frontend_model.svh"

  rx_frontend #(
    .SR_MAG(SR_MAG), .SR_PHASE(SR_PHASE), .SR_OFFSET_I(SR_OFFSET_I),
    .SR_OFFSET_Q(SR_OFFSET_Q), .SR_SWAP(SR_SWAP),
    .BYPASS_DC_OFFSET(1'b0), .BYPASS_IQ_COMP(1'b0)
  ) rx_frontend_i (
    .clk(clk), .reset(reset), .set_i(set_i), .adc_stb_i(adc_stb_i), .adc_i(adc_i),
    .rx_stb_o(rx_stb_o), .rx_o(rx_o));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Mismatch in %s: expected %08h, actual %08h", what, expected, actual);
    stop_run();
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Error: watchdog expired during %s before the run finished", test_name);
    stop_run();
  end

  // ########################################
  // model feed and output checks.
  // ########################################
  always @(posedge clk) begin : monitor
    pending_t head;
    pending_t entry;
    if (rx_stb_o) begin
      if (expect_q.size() == 0) begin
        $display("Error: unexpected output strobe during %s, nothing pending", test_name);
        stop_run();
      end else begin
        head = expect_q.pop_front();
        assert (rx_o == head.value) else report_mismatch(test_name, head.value, rx_o);
        assert (cycle_cnt == head.cycle + LATENCY)
          else report_mismatch({test_name, " latency"}, head.cycle + LATENCY, cycle_cnt);
      end
    end
    // sample first, the selector still holds the old flags here.
    if (adc_stb_i) begin
      entry.cycle = cycle_cnt;
      entry.value = model_sample(adc_i);
      expect_q.push_back(entry);
    end
    if (set_i.stb) begin
      model_write(set_i.addr, set_i.data);
    end
  end

  // ########################################
  // stimulus.
  // ########################################
  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    set_i <= '{stb: 1'b1, addr: addr, data: data};
    @(posedge clk);
    set_i <= '0;
  endtask

  // drain, load every register, then a quiet spell.
  task automatic configure(input string name, input logic [3:0] flags,
                           input logic [31:0] mag, input logic [31:0] phase,
                           input logic [31:0] ofs_i, input logic [31:0] ofs_q);
    repeat (2) @(posedge clk);
    while (expect_q.size() != 0) @(posedge clk);
    test_name = name;
    write_setting(SR_SWAP, {28'd0, flags});
    write_setting(SR_MAG, mag);
    write_setting(SR_PHASE, phase);
    write_setting(SR_OFFSET_I, ofs_i);
    write_setting(SR_OFFSET_Q, ofs_q);
    repeat (IDLE_CYCLES) @(posedge clk);
  endtask

  // kind 0 holds one value, 1 is random, 2 mixes in full scale corners.
  task automatic send_burst(input int kind, input int max_gap);
    logic [31:0] r;
    logic [31:0] c;
    logic [31:0] hold;
    rx_frontend_pkg::adc_sample_t s;
    hold = $random(seed);
    for (int n = 0; n < BURST_LEN; n++) begin
      r = $random(seed);
      c = $random(seed);
      s = (kind == 0) ? hold : r;
      if (kind == 2 && c[0]) begin
        s.i = c[1] ? 16'h7fff : 16'h8000;
      end
      if (kind == 2 && c[2]) begin
        s.q = c[3] ? 16'h7fff : 16'h8000;
      end
      adc_stb_i <= 1'b1;
      adc_i     <= s;
      @(posedge clk);
      adc_stb_i <= 1'b0;
      repeat (c[31:8] % (max_gap + 1)) @(posedge clk);
    end
  endtask

  initial begin
    logic [31:0] r;
    model_reset();
    reset     = 1'b1;
    set_i     = '0;
    adc_stb_i = 1'b0;
    adc_i     = '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    // tracking from a cleared accumulator.
    configure("passthrough", 4'b0000, 0, 0, 0, 0);
    send_burst(0, MAX_GAP);
    for (int b = 0; b < 4; b++) begin
      configure(flag_name[b], 4'b0001 << b, 0, 0, FIXED_ZERO, FIXED_ZERO);
      send_burst(1, MAX_GAP);
    end
    r = $random(seed);
    configure("fixed_offset", 4'b0000, 0, 0, {8'h80, r[23:0]}, {8'h80, r[31:8]});
    send_burst(1, MAX_GAP);
    configure("imbalance", 4'b0000, $random(seed), $random(seed), FIXED_ZERO, FIXED_ZERO);
    send_burst(2, MAX_GAP);
    configure("imbalance_extreme", 4'b0000, 32'h0002_0000, 32'h0001_ffff,
              FIXED_ZERO, FIXED_ZERO);
    send_burst(2, MAX_GAP);
    // consecutive samples with tracking and most flags on.
    configure("back_to_back", 4'b1101, $random(seed), $random(seed), 0, 0);
    send_burst(1, 0);
    repeat (LATENCY + 4) @(posedge clk);
    if (expect_q.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Error: %0d expected outputs never appeared", expect_q.size());
      stop_run();
    end
  end

endmodule

// ==== logic/rx_frontend.sv ====
// receive front end top level.
// selector, DC offset, imbalance and rounding stages in a chain.

`timescale 1ns/1ns

module rx_frontend #(
  parameter logic [7:0] SR_MAG           = 8'd1,
  parameter logic [7:0] SR_PHASE         = 8'd2,
  parameter logic [7:0] SR_OFFSET_I      = 8'd3,
  parameter logic [7:0] SR_OFFSET_Q      = 8'd4,
  parameter logic [7:0] SR_SWAP          = 8'd5,
  parameter bit         BYPASS_DC_OFFSET = 1'b0,
  parameter bit         BYPASS_IQ_COMP   = 1'b0
) (
  input  logic                           clk,
  input  logic                           reset,
  input  rx_frontend_pkg::settings_bus_t set_i,
  input  logic                           adc_stb_i,
  input  rx_frontend_pkg::adc_sample_t   adc_i,
  output logic                           rx_stb_o,
  output rx_frontend_pkg::adc_sample_t   rx_o
);

  localparam int FW = rx_frontend_pkg::SAMPLE_W - rx_frontend_pkg::ADC_W;

  rx_frontend_pkg::frontend_cfg_t cfg;
  logic                           sel_stb;
  rx_frontend_pkg::adc_sample_t   sel;
  rx_frontend_pkg::iq_sample_t    sel_wide;
  logic                           ofs_stb;
  rx_frontend_pkg::iq_sample_t    ofs;
  logic                           comp_stb;
  rx_frontend_pkg::iq_sample_t    comp;

  rx_settings_regs #(.SR_MAG(SR_MAG), .SR_PHASE(SR_PHASE), .SR_SWAP(SR_SWAP)) settings_i (
    .clk(clk), .reset(reset), .set_i(set_i), .cfg_o(cfg));

  rx_iq_select select_i (
    .clk(clk), .reset(reset), .cfg_i(cfg), .stb_i(adc_stb_i), .adc_i(adc_i),
    .stb_o(sel_stb), .sel_o(sel));

  // eight zero fraction bits below the converter word.
  assign sel_wide.i = {sel.i, {FW{1'b0}}};
  assign sel_wide.q = {sel.q, {FW{1'b0}}};

  if (BYPASS_DC_OFFSET) begin : g_dc_bypass
    assign ofs_stb = sel_stb;
    assign ofs     = sel_wide;
  end else begin : g_dc
    rx_dc_offset #(.SR_OFFSET_I(SR_OFFSET_I), .SR_OFFSET_Q(SR_OFFSET_Q)) dc_offset_i (
      .clk(clk), .reset(reset), .set_i(set_i), .stb_i(sel_stb), .in_i(sel_wide),
      .stb_o(ofs_stb), .out_o(ofs));
  end

  if (BYPASS_IQ_COMP) begin : g_comp_bypass
    assign comp_stb = ofs_stb;
    assign comp     = ofs;
  end else begin : g_comp
    rx_iq_balance balance_i (
      .clk(clk), .reset(reset), .cfg_i(cfg), .stb_i(ofs_stb), .in_i(ofs),
      .stb_o(comp_stb), .out_o(comp));
  end

  rx_round_sd round_i (
    .clk(clk), .reset(reset), .stb_i(comp_stb), .in_i(comp),
    .stb_o(rx_stb_o), .out_o(rx_o));

endmodule

// ==== logic/rx_round_sd.sv ====
// receive output rounder.
// 24 to 16 bits with error feedback and clipping.

`timescale 1ns/1ns

module rx_round_sd (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         stb_i,
  input  rx_frontend_pkg::iq_sample_t  in_i,
  output logic                         stb_o,
  output rx_frontend_pkg::adc_sample_t out_o
);

  localparam int SW = rx_frontend_pkg::SAMPLE_W;
  localparam int AW = rx_frontend_pkg::ADC_W;
  localparam int FW = SW - AW;

  logic signed [SW-1:0] in_ch  [2];
  logic [FW-1:0]        err_q  [2];
  logic signed [SW:0]   sum_ch [2];
  logic signed [AW-1:0] rnd_ch [2];

  always_comb begin
    in_ch[0] = in_i.i;
    in_ch[1] = in_i.q;
    for (int c = 0; c < 2; c++) begin
      sum_ch[c] = {in_ch[c][SW-1], in_ch[c]} + {{(AW+1){1'b0}}, err_q[c]};
      // shifted sum is one bit wider than the output.
      if (sum_ch[c][SW] != sum_ch[c][SW-1]) begin
        rnd_ch[c] = {sum_ch[c][SW], {(AW-1){~sum_ch[c][SW]}}};
      end else begin
        rnd_ch[c] = sum_ch[c][SW-1:FW];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_o <= 1'b0;
      for (int c = 0; c < 2; c++) begin
        err_q[c] <= '0;
      end
    end else begin
      stb_o <= stb_i;
      if (stb_i) begin
        for (int c = 0; c < 2; c++) begin
          err_q[c] <= sum_ch[c][FW-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stb_i) begin
      out_o.i <= rnd_ch[0];
      out_o.q <= rnd_ch[1];
    end
  end

endmodule

// ==== logic/rx_iq_balance.sv ====
// receive I/Q imbalance compensation.
// scaled copies of I are added to I and Q over two register stages.

`timescale 1ns/1ns

module rx_iq_balance (
  input  logic                           clk,
  input  logic                           reset,
  input  rx_frontend_pkg::frontend_cfg_t cfg_i,
  input  logic                           stb_i,
  input  rx_frontend_pkg::iq_sample_t    in_i,
  output logic                           stb_o,
  output rx_frontend_pkg::iq_sample_t    out_o
);

  localparam int SW = rx_frontend_pkg::SAMPLE_W;
  localparam int CW = rx_frontend_pkg::COEF_W;
  localparam int PW = 2 * CW;

  logic signed [CW-1:0]        i_top;
  logic signed [PW-1:0]        prod_mag_q;
  logic signed [PW-1:0]        prod_phase_q;
  rx_frontend_pkg::iq_sample_t dly_q;
  logic                        stb1_q;
  logic signed [SW-1:0]        sum_i;
  logic signed [SW-1:0]        sum_q;

  // top eighteen bits of I feed both multipliers.
  assign i_top = $signed(in_i.i[SW-1:SW-CW]);

  // ########################################
  // stage one, products.
  // ########################################
  always_ff @(posedge clk) begin
    if (stb_i) begin
      prod_mag_q   <= i_top * cfg_i.mag_corr;
      prod_phase_q <= i_top * cfg_i.phase_corr;
      dly_q        <= in_i;
    end
  end

  // ########################################
  // stage two, clipped adds.
  // ########################################
  always_comb begin
    sum_i = rx_frontend_pkg::sat_sample({dly_q.i[SW-1], dly_q.i} +
                                        {prod_mag_q[PW-1], prod_mag_q[PW-1:PW-SW]});
    sum_q = rx_frontend_pkg::sat_sample({dly_q.q[SW-1], dly_q.q} +
                                        {prod_phase_q[PW-1], prod_phase_q[PW-1:PW-SW]});
  end

  always_ff @(posedge clk) begin
    if (stb1_q) begin
      out_o.i <= sum_i;
      out_o.q <= sum_q;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stb1_q <= 1'b0;
      stb_o  <= 1'b0;
    end else begin
      stb1_q <= stb_i;
      stb_o  <= stb1_q;
    end
  end

endmodule

// ==== logic/rx_dc_offset.sv ====
// receive DC offset removal for both channels.
// tracking integrator per channel, or a fixed offset loaded over settings.

`timescale 1ns/1ns

module rx_dc_offset #(
  parameter logic [7:0] SR_OFFSET_I = 8'd3,
  parameter logic [7:0] SR_OFFSET_Q = 8'd4
) (
  input  logic                           clk,
  input  logic                           reset,
  input  rx_frontend_pkg::settings_bus_t set_i,
  input  logic                           stb_i,
  input  rx_frontend_pkg::iq_sample_t    in_i,
  output logic                           stb_o,
  output rx_frontend_pkg::iq_sample_t    out_o
);

  localparam int SW    = rx_frontend_pkg::SAMPLE_W;
  localparam int ACC_W = 32;

  // index 0 is I, index 1 is Q.
  logic signed [SW-1:0]    in_ch   [2];
  logic signed [SW-1:0]    diff_ch [2];
  logic signed [ACC_W-1:0] acc_q   [2];
  logic                    fixed_q [2];
  logic                    hit     [2];

  assign hit[0] = set_i.stb && (set_i.addr == SR_OFFSET_I);
  assign hit[1] = set_i.stb && (set_i.addr == SR_OFFSET_Q);

  // ########################################
  // offset subtraction.
  // ########################################
  always_comb begin
    in_ch[0] = in_i.i;
    in_ch[1] = in_i.q;
    for (int c = 0; c < 2; c++) begin
      // upper bits of the accumulator hold the offset estimate.
      diff_ch[c] = rx_frontend_pkg::sat_sample({in_ch[c][SW-1], in_ch[c]} -
                                               {acc_q[c][ACC_W-1],
                                                acc_q[c][ACC_W-1:ACC_W-SW]});
    end
  end

  // ########################################
  // integrators.
  // ########################################
  always_ff @(posedge clk) begin
    if (reset) begin
      stb_o <= 1'b0;
      for (int c = 0; c < 2; c++) begin
        acc_q[c]   <= '0;
        fixed_q[c] <= 1'b0;
      end
    end else begin
      stb_o <= stb_i;
      for (int c = 0; c < 2; c++) begin
        if (hit[c]) begin
          // a load wins over a tracking update in the same cycle.
          acc_q[c]   <= {set_i.data[SW-1:0], {(ACC_W-SW){1'b0}}};
          fixed_q[c] <= set_i.data[31];
        end else if (stb_i && !fixed_q[c]) begin
          acc_q[c] <= acc_q[c] + {{(ACC_W-SW){diff_ch[c][SW-1]}}, diff_ch[c]};
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stb_i) begin
      out_o.i <= diff_ch[0];
      out_o.q <= diff_ch[1];
    end
  end

endmodule

// ==== logic/rx_iq_select.sv ====
// receive I/Q selector.
// registered swap, per-channel inversion and real mode.

`timescale 1ns/1ns

module rx_iq_select (
  input  logic                           clk,
  input  logic                           reset,
  input  rx_frontend_pkg::frontend_cfg_t cfg_i,
  input  logic                           stb_i,
  input  rx_frontend_pkg::adc_sample_t   adc_i,
  output logic                           stb_o,
  output rx_frontend_pkg::adc_sample_t   sel_o
);

  rx_frontend_pkg::adc_sample_t swapped;
  rx_frontend_pkg::adc_sample_t sel_d;

  // swap first, inversion applies to the swapped channels.
  always_comb begin
    swapped.i = cfg_i.swap_iq ? adc_i.q : adc_i.i;
    swapped.q = cfg_i.swap_iq ? adc_i.i : adc_i.q;
    sel_d.i   = cfg_i.invert_i ? ~swapped.i : swapped.i;
    if (cfg_i.realmode) begin
      sel_d.q = '0;
    end else begin
      sel_d.q = cfg_i.invert_q ? ~swapped.q : swapped.q;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_o <= 1'b0;
    end else begin
      stb_o <= stb_i;
    end
  end

  always_ff @(posedge clk) begin
    if (stb_i) begin
      sel_o <= sel_d;
    end
  end

endmodule

// ==== logic/rx_settings_regs.sv ====
// receive front end settings registers.
// decodes settings bus writes into selector flags and coefficients.

`timescale 1ns/1ns

module rx_settings_regs #(
  parameter logic [7:0] SR_MAG   = 8'd1,
  parameter logic [7:0] SR_PHASE = 8'd2,
  parameter logic [7:0] SR_SWAP  = 8'd5
) (
  input  logic                           clk,
  input  logic                           reset,
  input  rx_frontend_pkg::settings_bus_t set_i,
  output rx_frontend_pkg::frontend_cfg_t cfg_o
);

  localparam int CW = rx_frontend_pkg::COEF_W;

  logic signed [CW-1:0] mag_q;
  logic signed [CW-1:0] phase_q;
  logic [3:0]           flags_q;

  // ########################################
  // address matched registers.
  // ########################################
  always_ff @(posedge clk) begin
    if (reset) begin
      mag_q   <= '0;
      phase_q <= '0;
      flags_q <= '0;
    end else if (set_i.stb) begin
      if (set_i.addr == SR_MAG) begin
        mag_q <= set_i.data[CW-1:0];
      end
      if (set_i.addr == SR_PHASE) begin
        phase_q <= set_i.data[CW-1:0];
      end
      if (set_i.addr == SR_SWAP) begin
        flags_q <= set_i.data[3:0];
      end
    end
  end

  // ########################################
  // flag unpacking.
  // ########################################
  // bit order, msb first: invert_i, invert_q, realmode, swap_iq.
  always_comb begin
    cfg_o.invert_i   = flags_q[3];
    cfg_o.invert_q   = flags_q[2];
    cfg_o.realmode   = flags_q[1];
    cfg_o.swap_iq    = flags_q[0];
    cfg_o.mag_corr   = mag_q;
    cfg_o.phase_corr = phase_q;
  end

endmodule

// ==== logic/rx_frontend_pkg.sv ====
// receive front end shared types.
// sample, configuration and settings bus structs plus widths.

package rx_frontend_pkg;

  // ########################################
  // widths.
  // ########################################
  localparam int ADC_W    = 16;
  localparam int SAMPLE_W = 24;
  localparam int COEF_W   = 18;

  // ########################################
  // structs.
  // ########################################
  // raw converter sample, sc16.
  typedef struct packed {
    logic signed [ADC_W-1:0] i;
    logic signed [ADC_W-1:0] q;
  } adc_sample_t;

  // internal sample with eight fraction bits.
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] i;
    logic signed [SAMPLE_W-1:0] q;
  } iq_sample_t;

  // one settings bus write.
  typedef struct packed {
    logic        stb;
    logic [7:0]  addr;
    logic [31:0] data;
  } settings_bus_t;

  // selector flags and imbalance coefficients.
  typedef struct packed {
    logic                     swap_iq;
    logic                     realmode;
    logic                     invert_i;
    logic                     invert_q;
    logic signed [COEF_W-1:0] mag_corr;
    logic signed [COEF_W-1:0] phase_corr;
  } frontend_cfg_t;

  // clip a one-bit-grown sum back to sample width.
  function automatic logic signed [SAMPLE_W-1:0] sat_sample(input logic signed [SAMPLE_W:0] x);
    if (x[SAMPLE_W] != x[SAMPLE_W-1]) begin
      return {x[SAMPLE_W], {(SAMPLE_W-1){~x[SAMPLE_W]}}};
    end
    return x[SAMPLE_W-1:0];
  endfunction

endpackage
